/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // grant owner of the shared memory bus.
    // the lsu outranks the ifu whenever both are waiting.
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,  // nobody owns the bus.
        ARB_IFU  = 2'd1,  // instruction fetch owns the bus.
        ARB_LSU  = 2'd2   // load/store owns the bus.
    } arb_state_t;

    // one-bit response carried on rresp and bresp.
    // only two outcomes exist on this bus, so the usual two-bit code is folded down.
    typedef enum logic {
        RESP_OKAY = 1'b0,  // access done.
        RESP_ERR  = 1'b1   // address outside the memory.
    } bus_resp_t;

endpackage

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import bus_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 32
) (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire                      ifu_req,
    input  wire                      lsu_req,

    input  wire  [ADDR_WIDTH-1:0]    ifu_araddr,
    input  wire                      ifu_arvalid,
    output logic                     ifu_arready,
    output logic [DATA_WIDTH-1:0]    ifu_rdata,
    output bus_resp_t                ifu_rresp,
    output logic                     ifu_rvalid,
    input  wire                      ifu_rready,
    input  wire  [ADDR_WIDTH-1:0]    ifu_awaddr,
    input  wire                      ifu_awvalid,
    output logic                     ifu_awready,
    input  wire  [DATA_WIDTH-1:0]    ifu_wdata,
    input  wire  [DATA_WIDTH/8-1:0]  ifu_wstrb,
    input  wire                      ifu_wvalid,
    output logic                     ifu_wready,
    output bus_resp_t                ifu_bresp,
    output logic                     ifu_bvalid,
    input  wire                      ifu_bready,

    input  wire  [ADDR_WIDTH-1:0]    lsu_araddr,
    input  wire                      lsu_arvalid,
    output logic                     lsu_arready,
    output logic [DATA_WIDTH-1:0]    lsu_rdata,
    output bus_resp_t                lsu_rresp,
    output logic                     lsu_rvalid,
    input  wire                      lsu_rready,
    input  wire  [ADDR_WIDTH-1:0]    lsu_awaddr,
    input  wire                      lsu_awvalid,
    output logic                     lsu_awready,
    input  wire  [DATA_WIDTH-1:0]    lsu_wdata,
    input  wire  [DATA_WIDTH/8-1:0]  lsu_wstrb,
    input  wire                      lsu_wvalid,
    output logic                     lsu_wready,
    output bus_resp_t                lsu_bresp,
    output logic                     lsu_bvalid,
    input  wire                      lsu_bready,

    output logic [ADDR_WIDTH-1:0]    mem_araddr,
    output logic                     mem_arvalid,
    input  wire                      mem_arready,
    input  wire  [DATA_WIDTH-1:0]    mem_rdata,
    input  wire  bus_resp_t          mem_rresp,
    input  wire                      mem_rvalid,
    output logic                     mem_rready,
    output logic [ADDR_WIDTH-1:0]    mem_awaddr,
    output logic                     mem_awvalid,
    input  wire                      mem_awready,
    output logic [DATA_WIDTH-1:0]    mem_wdata,
    output logic [DATA_WIDTH/8-1:0]  mem_wstrb,
    output logic                     mem_wvalid,
    input  wire                      mem_wready,
    input  wire  bus_resp_t          mem_bresp,
    input  wire                      mem_bvalid,
    output logic                     mem_bready
);

    arb_state_t grant;
    arb_state_t grant_next;
    logic       owner_done;

    // the owner is finished once its read data or write response is taken.
    assign owner_done = (mem_rvalid && mem_rready) || (mem_bvalid && mem_bready);

    always_comb begin
        grant_next = grant;
        if (grant == ARB_IDLE || owner_done) begin  // free bus, or released this cycle.
            if (lsu_req) begin
                grant_next = ARB_LSU;
            end else if (ifu_req) begin
                grant_next = ARB_IFU;
            end else begin
                grant_next = ARB_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= ARB_IDLE;
        end else begin
            grant <= grant_next;
        end
    end

    always_comb begin
        mem_araddr  = '0;  // with no owner the bus stays quiet.
        mem_arvalid = 1'b0;
        mem_rready  = 1'b0;
        mem_awaddr  = '0;
        mem_awvalid = 1'b0;
        mem_wdata   = '0;
        mem_wstrb   = '0;
        mem_wvalid  = 1'b0;
        mem_bready  = 1'b0;

        ifu_arready = 1'b0;
        ifu_rdata   = '0;
        ifu_rresp   = RESP_OKAY;
        ifu_rvalid  = 1'b0;
        ifu_awready = 1'b0;
        ifu_wready  = 1'b0;
        ifu_bresp   = RESP_OKAY;
        ifu_bvalid  = 1'b0;

        lsu_arready = 1'b0;
        lsu_rdata   = '0;
        lsu_rresp   = RESP_OKAY;
        lsu_rvalid  = 1'b0;
        lsu_awready = 1'b0;
        lsu_wready  = 1'b0;
        lsu_bresp   = RESP_OKAY;
        lsu_bvalid  = 1'b0;

        case (grant)
            ARB_IFU: begin
                mem_araddr  = ifu_araddr;
                mem_arvalid = ifu_arvalid;
                mem_rready  = ifu_rready;
                mem_awaddr  = ifu_awaddr;
                mem_awvalid = ifu_awvalid;
                mem_wdata   = ifu_wdata;
                mem_wstrb   = ifu_wstrb;
                mem_wvalid  = ifu_wvalid;
                mem_bready  = ifu_bready;
                ifu_arready = mem_arready;
                ifu_rdata   = mem_rdata;
                ifu_rresp   = mem_rresp;
                ifu_rvalid  = mem_rvalid;
                ifu_awready = mem_awready;
                ifu_wready  = mem_wready;
                ifu_bresp   = mem_bresp;
                ifu_bvalid  = mem_bvalid;
            end
            ARB_LSU: begin
                mem_araddr  = lsu_araddr;
                mem_arvalid = lsu_arvalid;
                mem_rready  = lsu_rready;
                mem_awaddr  = lsu_awaddr;
                mem_awvalid = lsu_awvalid;
                mem_wdata   = lsu_wdata;
                mem_wstrb   = lsu_wstrb;
                mem_wvalid  = lsu_wvalid;
                mem_bready  = lsu_bready;
                lsu_arready = mem_arready;
                lsu_rdata   = mem_rdata;
                lsu_rresp   = mem_rresp;
                lsu_rvalid  = mem_rvalid;
                lsu_awready = mem_awready;
                lsu_wready  = mem_wready;
                lsu_bresp   = mem_bresp;
                lsu_bvalid  = mem_bvalid;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/axi_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_sram import bus_pkg::*; #(
    parameter int DATA_WIDTH   = 32,
    parameter int ADDR_WIDTH   = 32,
    parameter int MEM_DEPTH    = 256,
    parameter int READ_LATENCY = 2
) (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire  [ADDR_WIDTH-1:0]    mem_araddr,
    input  wire                      mem_arvalid,
    output logic                     mem_arready,
    output logic [DATA_WIDTH-1:0]    mem_rdata,
    output bus_resp_t                mem_rresp,
    output logic                     mem_rvalid,
    input  wire                      mem_rready,
    input  wire  [ADDR_WIDTH-1:0]    mem_awaddr,
    input  wire                      mem_awvalid,
    output logic                     mem_awready,
    input  wire  [DATA_WIDTH-1:0]    mem_wdata,
    input  wire  [DATA_WIDTH/8-1:0]  mem_wstrb,
    input  wire                      mem_wvalid,
    output logic                     mem_wready,
    output bus_resp_t                mem_bresp,
    output logic                     mem_bvalid,
    input  wire                      mem_bready
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int ADDR_LSB   = $clog2(STRB_WIDTH);
    localparam int IDX_WIDTH  = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int CNT_WIDTH  = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;

    typedef enum logic [2:0] {
        SRAM_IDLE,
        SRAM_RD_WAIT,
        SRAM_WR_WAIT,
        SRAM_RD_RESP,
        SRAM_WR_RESP
    } sram_state_t;

    sram_state_t           state;
    logic [CNT_WIDTH-1:0]  wait_cnt;
    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic [DATA_WIDTH-1:0] rdata_q;
    bus_resp_t             resp_q;
    logic [ADDR_WIDTH-1:0] rd_word;
    logic [ADDR_WIDTH-1:0] wr_word;
    logic                  rd_hit;
    logic                  wr_hit;
    logic                  rd_accept;
    logic                  wr_accept;

    assign rd_word = mem_araddr >> ADDR_LSB;  // byte address to word index.
    assign wr_word = mem_awaddr >> ADDR_LSB;
    assign rd_hit  = rd_word < MEM_DEPTH;
    assign wr_hit  = wr_word < MEM_DEPTH;

    // a pending read wins over a write offered in the same cycle.
    assign mem_arready = (state == SRAM_IDLE);
    assign mem_awready = (state == SRAM_IDLE) && mem_awvalid && mem_wvalid && !mem_arvalid;
    assign mem_wready  = mem_awready;

    assign rd_accept = mem_arvalid && mem_arready;
    assign wr_accept = mem_awvalid && mem_awready && mem_wvalid && mem_wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SRAM_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                SRAM_IDLE: begin
                    wait_cnt <= CNT_WIDTH'(READ_LATENCY - 1);
                    if (rd_accept) begin
                        state <= SRAM_RD_WAIT;
                    end else if (wr_accept) begin
                        state <= SRAM_WR_WAIT;
                    end
                end
                SRAM_RD_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= SRAM_RD_RESP;  // valid rises latency edges after accept.
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                SRAM_WR_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= SRAM_WR_RESP;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                SRAM_RD_RESP: begin
                    if (mem_rready) begin
                        state <= SRAM_IDLE;  // held here until the master takes it.
                    end
                end
                SRAM_WR_RESP: begin
                    if (mem_bready) begin
                        state <= SRAM_IDLE;
                    end
                end
                default: begin
                    state <= SRAM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_q <= rd_hit ? mem[rd_word[IDX_WIDTH-1:0]] : '0;
            resp_q  <= rd_hit ? RESP_OKAY : RESP_ERR;
        end else if (wr_accept) begin
            resp_q <= wr_hit ? RESP_OKAY : RESP_ERR;
            if (wr_hit) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (mem_wstrb[b]) begin
                        mem[wr_word[IDX_WIDTH-1:0]][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign mem_rdata  = rdata_q;
    assign mem_rresp  = resp_q;
    assign mem_rvalid = (state == SRAM_RD_RESP);
    assign mem_bresp  = resp_q;  // reads and writes never overlap, so one register serves both.
    assign mem_bvalid = (state == SRAM_WR_RESP);

endmodule

`default_nettype wire

/* design/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem import bus_pkg::*; #(
    parameter int DATA_WIDTH   = 32,
    parameter int ADDR_WIDTH   = 32,
    parameter int MEM_DEPTH    = 256,
    parameter int READ_LATENCY = 2
) (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire                      ifu_req,
    input  wire                      lsu_req,

    input  wire  [ADDR_WIDTH-1:0]    ifu_araddr,
    input  wire                      ifu_arvalid,
    output logic                     ifu_arready,
    output logic [DATA_WIDTH-1:0]    ifu_rdata,
    output bus_resp_t                ifu_rresp,
    output logic                     ifu_rvalid,
    input  wire                      ifu_rready,
    input  wire  [ADDR_WIDTH-1:0]    ifu_awaddr,
    input  wire                      ifu_awvalid,
    output logic                     ifu_awready,
    input  wire  [DATA_WIDTH-1:0]    ifu_wdata,
    input  wire  [DATA_WIDTH/8-1:0]  ifu_wstrb,
    input  wire                      ifu_wvalid,
    output logic                     ifu_wready,
    output bus_resp_t                ifu_bresp,
    output logic                     ifu_bvalid,
    input  wire                      ifu_bready,

    input  wire  [ADDR_WIDTH-1:0]    lsu_araddr,
    input  wire                      lsu_arvalid,
    output logic                     lsu_arready,
    output logic [DATA_WIDTH-1:0]    lsu_rdata,
    output bus_resp_t                lsu_rresp,
    output logic                     lsu_rvalid,
    input  wire                      lsu_rready,
    input  wire  [ADDR_WIDTH-1:0]    lsu_awaddr,
    input  wire                      lsu_awvalid,
    output logic                     lsu_awready,
    input  wire  [DATA_WIDTH-1:0]    lsu_wdata,
    input  wire  [DATA_WIDTH/8-1:0]  lsu_wstrb,
    input  wire                      lsu_wvalid,
    output logic                     lsu_wready,
    output bus_resp_t                lsu_bresp,
    output logic                     lsu_bvalid,
    input  wire                      lsu_bready
);

    // shared bus between the arbiter and the memory.
    logic [ADDR_WIDTH-1:0]   mem_araddr;
    logic                    mem_arvalid;
    logic                    mem_arready;
    logic [DATA_WIDTH-1:0]   mem_rdata;
    bus_resp_t               mem_rresp;
    logic                    mem_rvalid;
    logic                    mem_rready;
    logic [ADDR_WIDTH-1:0]   mem_awaddr;
    logic                    mem_awvalid;
    logic                    mem_awready;
    logic [DATA_WIDTH-1:0]   mem_wdata;
    logic [DATA_WIDTH/8-1:0] mem_wstrb;
    logic                    mem_wvalid;
    logic                    mem_wready;
    bus_resp_t               mem_bresp;
    logic                    mem_bvalid;
    logic                    mem_bready;

    bus_arbiter #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) arb0 (.*);  // port names match the master ports and the mem_ wires.

    axi_sram #(
        .DATA_WIDTH   (DATA_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .MEM_DEPTH    (MEM_DEPTH),
        .READ_LATENCY (READ_LATENCY)
    ) sram0 (.*);

endmodule

`default_nettype wire

/* testbench/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// galois lfsr, taps for x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        v = (v << 1) | int'(lfsr_state[0]);
        lfsr_state = lfsr_next(lfsr_state);  // one step per bit taken.
    end
    return v;
endfunction

function automatic void check_value(input string name, input logic [31:0] exp,
                                    input logic [31:0] act);
    assert (exp === act) else begin
        value_errs++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    end
endfunction

// index 0 is the ifu port, index 1 the lsu port.
task automatic do_read(input int m, input logic [31:0] addr, input int bp,
                       output logic [31:0] data, output bus_resp_t resp, output int lat);
    int start;
    int n;
    logic [31:0] held_d;
    bus_resp_t held_r;
    data = '0;
    resp = RESP_ERR;
    lat = -1;
    start = cyc;
    req[m] = 1'b1;
    araddr[m] = addr;
    arvalid[m] = 1'b1;
    n = 0;
    @(negedge clk);
    while (!arready[m] && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    @(posedge clk);
    #10;
    arvalid[m] = 1'b0;
    if (n == TIMEOUT) begin
        timeout_errs++;
        $display("master %0d read address was never accepted", m);
        req[m] = 1'b0;
        return;
    end
    n = 0;
    @(negedge clk);
    while (!rvalid[m] && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (n == TIMEOUT) begin
        timeout_errs++;
        $display("master %0d never saw read data", m);
        req[m] = 1'b0;
        return;
    end
    lat = cyc - start;
    held_d = rdata[m];
    held_r = rresp[m];
    repeat (bp) begin
        @(negedge clk);
        assert (rvalid[m] === 1'b1 && rdata[m] === held_d && rresp[m] === held_r) else begin
            value_errs++;
            $display("master %0d read data was not held while rready was low", m);
        end
    end
    @(posedge clk);
    #10;
    rready[m] = 1'b1;
    req[m] = 1'b0;  // dropped with rready, so the grant is released at the handshake.
    @(negedge clk);
    assert (rvalid[m] === 1'b1 && rdata[m] === held_d && rresp[m] === held_r) else begin
        value_errs++;
        $display("master %0d read data changed before it was accepted", m);
    end
    @(posedge clk);
    #10;
    rready[m] = 1'b0;
    @(negedge clk);
    assert (rvalid[m] !== 1'b1) else begin
        value_errs++;
        $display("master %0d got a second read response", m);
    end
    @(posedge clk);
    #10;
    data = held_d;
    resp = held_r;
endtask

task automatic do_write(input int m, input logic [31:0] addr, input logic [31:0] d,
                        input logic [3:0] strb, input int bp, output bus_resp_t resp);
    int n;
    bus_resp_t held_r;
    resp = RESP_ERR;
    req[m] = 1'b1;
    awaddr[m] = addr;
    wdata[m] = d;
    wstrb[m] = strb;
    awvalid[m] = 1'b1;
    wvalid[m] = 1'b1;
    n = 0;
    @(negedge clk);
    while (!(awready[m] && wready[m]) && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    @(posedge clk);
    #10;
    awvalid[m] = 1'b0;
    wvalid[m] = 1'b0;
    if (n == TIMEOUT) begin
        timeout_errs++;
        $display("master %0d write was never accepted", m);
        req[m] = 1'b0;
        return;
    end
    n = 0;
    @(negedge clk);
    while (!bvalid[m] && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (n == TIMEOUT) begin
        timeout_errs++;
        $display("master %0d never saw a write response", m);
        req[m] = 1'b0;
        return;
    end
    held_r = bresp[m];
    repeat (bp) begin
        @(negedge clk);
        assert (bvalid[m] === 1'b1 && bresp[m] === held_r) else begin
            value_errs++;
            $display("master %0d write response was not held while bready was low", m);
        end
    end
    @(posedge clk);
    #10;
    bready[m] = 1'b1;
    req[m] = 1'b0;
    @(negedge clk);
    assert (bvalid[m] === 1'b1 && bresp[m] === held_r) else begin
        value_errs++;
        $display("master %0d write response changed before it was accepted", m);
    end
    @(posedge clk);
    #10;
    bready[m] = 1'b0;
    @(negedge clk);
    assert (bvalid[m] !== 1'b1) else begin
        value_errs++;
        $display("master %0d got a second write response", m);
    end
    @(posedge clk);
    #10;
    resp = held_r;
endtask

`endif

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem import bus_pkg::*; ();

    localparam int TIMEOUT = 50;
    localparam int MEM_DEPTH = 256;
    localparam int READ_LATENCY = 2;
    localparam int NUM_ENTRIES = 16;
    localparam int OP_RD = 0;
    localparam int OP_WR = 1;
    localparam int OP_PAIR = 2;  // lsu reads addr, ifu reads addr2 in the same cycle.

    typedef struct {
        arb_state_t  who;
        int          op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] addr2;
    } entry_t;

    entry_t stim [NUM_ENTRIES] = '{
        '{ARB_LSU, OP_WR,   32'h010, 32'hdeadbeef, 4'hf, 32'h0},
        '{ARB_IFU, OP_RD,   32'h010, 32'h0,        4'h0, 32'h0},
        '{ARB_IFU, OP_WR,   32'h010, 32'h11223344, 4'h5, 32'h0},
        '{ARB_LSU, OP_RD,   32'h010, 32'h0,        4'h0, 32'h0},
        '{ARB_IFU, OP_WR,   32'h024, 32'hcafef00d, 4'hf, 32'h0},
        '{ARB_LSU, OP_WR,   32'h024, 32'ha5000000, 4'h8, 32'h0},
        '{ARB_IFU, OP_RD,   32'h024, 32'h0,        4'h0, 32'h0},
        '{ARB_LSU, OP_WR,   32'h000, 32'h0badf00d, 4'hf, 32'h0},
        '{ARB_LSU, OP_WR,   32'h3fc, 32'h5a5a1234, 4'hf, 32'h0},
        '{ARB_LSU, OP_WR,   32'h400, 32'h12345678, 4'hf, 32'h0},
        '{ARB_IFU, OP_RD,   32'h400, 32'h0,        4'h0, 32'h0},
        '{ARB_IFU, OP_WR,   32'h7fc, 32'hffffffff, 4'hf, 32'h0},
        '{ARB_LSU, OP_RD,   32'h000, 32'h0,        4'h0, 32'h0},
        '{ARB_IFU, OP_RD,   32'h3fc, 32'h0,        4'h0, 32'h0},
        '{ARB_LSU, OP_PAIR, 32'h010, 32'h0,        4'h0, 32'h024},
        '{ARB_IFU, OP_PAIR, 32'h024, 32'h0,        4'h0, 32'h000}
    };

    logic clk;
    logic rst_n;
    logic [31:0] lfsr_state = 32'h997a77f6;
    int cyc = 0;
    int value_errs = 0;
    int timeout_errs = 0;
    logic [31:0] ref_mem [MEM_DEPTH];

    logic        req [2];
    logic [31:0] araddr [2];
    logic        arvalid [2];
    logic        arready [2];
    logic [31:0] rdata [2];
    bus_resp_t   rresp [2];
    logic        rvalid [2];
    logic        rready [2];
    logic [31:0] awaddr [2];
    logic        awvalid [2];
    logic        awready [2];
    logic [31:0] wdata [2];
    logic [3:0]  wstrb [2];
    logic        wvalid [2];
    logic        wready [2];
    bus_resp_t   bresp [2];
    logic        bvalid [2];
    logic        bready [2];

    mem_subsystem dut0 (
        .clk(clk), .rst_n(rst_n), .ifu_req(req[0]), .lsu_req(req[1]),
        .ifu_araddr(araddr[0]), .ifu_arvalid(arvalid[0]), .ifu_arready(arready[0]),
        .ifu_rdata(rdata[0]), .ifu_rresp(rresp[0]), .ifu_rvalid(rvalid[0]),
        .ifu_rready(rready[0]), .ifu_awaddr(awaddr[0]), .ifu_awvalid(awvalid[0]),
        .ifu_awready(awready[0]), .ifu_wdata(wdata[0]), .ifu_wstrb(wstrb[0]),
        .ifu_wvalid(wvalid[0]), .ifu_wready(wready[0]), .ifu_bresp(bresp[0]),
        .ifu_bvalid(bvalid[0]), .ifu_bready(bready[0]),
        .lsu_araddr(araddr[1]), .lsu_arvalid(arvalid[1]), .lsu_arready(arready[1]),
        .lsu_rdata(rdata[1]), .lsu_rresp(rresp[1]), .lsu_rvalid(rvalid[1]),
        .lsu_rready(rready[1]), .lsu_awaddr(awaddr[1]), .lsu_awvalid(awvalid[1]),
        .lsu_awready(awready[1]), .lsu_wdata(wdata[1]), .lsu_wstrb(wstrb[1]),
        .lsu_wvalid(wvalid[1]), .lsu_wready(wready[1]), .lsu_bresp(bresp[1]),
        .lsu_bvalid(bvalid[1]), .lsu_bready(bready[1])
    );

    `include "tb_bus_tasks.svh"

    function automatic logic in_range(input logic [31:0] addr);
        return (addr >> 2) < MEM_DEPTH;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        return in_range(addr) ? ref_mem[addr >> 2] : 32'h0;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] d,
                                        input logic [3:0] strb);
        if (in_range(addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_mem[addr >> 2][b*8 +: 8] = d[b*8 +: 8];
                end
            end
        end
    endfunction

    function automatic void check_quiet(input string name);
        for (int m = 0; m < 2; m++) begin
            assert (arready[m] === 1'b0 && rvalid[m] === 1'b0 && awready[m] === 1'b0 &&
                    wready[m] === 1'b0 && bvalid[m] === 1'b0) else begin
                value_errs++;
                $display("%s: a valid or ready on master %0d is not low", name, m);
            end
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        entry_t e;
        int m;
        int bp;
        int bp2;
        int lat;
        int lat2;
        int w;
        logic [31:0] d;
        logic [31:0] d2;
        bus_resp_t r;
        bus_resp_t r2;
        string name;
        rst_n = 1'b0;
        for (int i = 0; i < 2; i++) begin
            req[i] = 1'b0;
            araddr[i] = '0;
            arvalid[i] = 1'b0;
            rready[i] = 1'b0;
            awaddr[i] = '0;
            awvalid[i] = 1'b0;
            wdata[i] = '0;
            wstrb[i] = '0;
            wvalid[i] = 1'b0;
            bready[i] = 1'b0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            ref_mem[i] = 32'h0;
        end
        repeat (16) begin
            @(negedge clk);
            check_quiet("reset");
        end
        @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet("after reset");
        @(posedge clk);
        #10;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = stim[i];
            m = (e.who == ARB_LSU) ? 1 : 0;
            name = $sformatf("entry%0d", i);
            bp = take_bits(3);
            if (e.op == OP_WR) begin
                do_write(m, e.addr, e.data, e.strb, bp, r);
                check_value({name, " bresp"}, in_range(e.addr) ? RESP_OKAY : RESP_ERR, r);
                model_write(e.addr, e.data, e.strb);
            end else if (e.op == OP_RD) begin
                do_read(m, e.addr, bp, d, r, lat);
                check_value({name, " rdata"}, model_read(e.addr), d);
                check_value({name, " rresp"}, in_range(e.addr) ? RESP_OKAY : RESP_ERR, r);
                check_value({name, " latency"}, READ_LATENCY + 2, lat);
            end else begin
                bp2 = take_bits(3);
                fork
                    do_read(1, e.addr, bp, d, r, lat);
                    do_read(0, e.addr2, bp2, d2, r2, lat2);
                    begin  // the ifu must stay shut out while lsu owns the bus.
                        w = 0;
                        @(negedge clk);
                        while (req[1] && w < TIMEOUT) begin
                            assert (arready[0] !== 1'b1 && rvalid[0] !== 1'b1) else begin
                                value_errs++;
                                $display("%s: ifu saw arready or rvalid during lsu grant", name);
                            end
                            @(negedge clk);
                            w++;
                        end
                        if (req[1]) begin
                            timeout_errs++;
                            $display("%s: lsu request was never dropped", name);
                        end
                    end
                join
                check_value({name, " lsu rdata"}, model_read(e.addr), d);
                check_value({name, " ifu rdata"}, model_read(e.addr2), d2);
                check_value({name, " lsu rresp"}, RESP_OKAY, r);
                check_value({name, " ifu rresp"}, RESP_OKAY, r2);
                check_value({name, " lsu latency"}, READ_LATENCY + 2, lat);
                assert (lat < lat2) else begin
                    value_errs++;
                    $display("%s: ifu read data came before lsu read data", name);
                end
            end
        end
        $display("value errors %0d, timeout errors %0d", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/bus_pkg.sv
design/bus_arbiter.sv
design/axi_sram.sv
design/mem_subsystem.sv
+incdir+testbench
testbench/tb_mem_subsystem.sv
